// ==== rtl/i2c_sensor_consts.svh ====
`default_nettype none

`ifndef I2C_SENSOR_CONSTS_SVH
`define I2C_SENSOR_CONSTS_SVH

// 7-bit target address out of reset
`define I2C_RESET_ADDR  7'h10

// register map
`define REG_DEVICE_ADDR 16'h0000 // holds the matched device address
`define REG_ID_FIRST    16'h0001 // identity bytes
`define REG_ID_LAST     16'h0004
`define REG_RW_FIRST    16'h0005 // read/write bytes
`define REG_RW_LAST     16'h000C

// identity byte k reads base plus k
`define ID_BASE_VAL     8'hA0

// read/write byte k resets to base plus k
`define RW_RESET_BASE   8'hB0

// returned for unmapped addresses
`define RD_FILL_VAL     8'hFF

`endif

`default_nettype wire

// ==== rtl/i2c_sensor_pkg.sv ====
`default_nettype none

package i2c_sensor_pkg;

	// bit engine to controller, every flag is a one-cycle strobe
	typedef struct packed {
		logic       start;      // start or repeated start
		logic       stop;
		logic       byte_vld;   // byte received, or ninth bit of a sent byte
		logic       master_ack; // master acked the sent byte
		logic [7:0] rx_byte;    // valid with byte_vld in receive mode
	} bus_ev_t;

	// controller to bit engine
	typedef struct packed {
		logic       ack_en;  // level, ack the next ninth bit
		logic       tx_mode; // level, shift bytes out
		logic       tx_load; // strobe, take tx_byte
		logic [7:0] tx_byte;
	} bit_ctl_t;

	// controller to register file
	typedef struct packed {
		logic        wr_stb;
		logic        rd_stb;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} reg_req_t;

endpackage

`default_nettype wire

// ==== rtl/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine import i2c_sensor_pkg::*; (
	input  logic     sys_clk,
	input  logic     rst_n,
	input  logic     scl_i,
	input  logic     sda_i,
	input  bit_ctl_t ctl_i,
	output bus_ev_t  ev_o,
	output logic     sda_oe_o
);

	logic [1:0] scl_sync;
	logic [1:0] sda_sync;
	logic       scl_q;
	logic       sda_q;
	logic       scl_rise;
	logic       scl_fall;
	logic       bus_start;
	logic       bus_stop;
	logic [3:0] bit_cnt;
	logic [7:0] rx_sh;
	logic [7:0] tx_sh;
	logic       tx_full;
	logic       tx_busy;
	logic       sda_oe_q;
	bus_ev_t    ev_q;

	// two-flop synchronizers plus one delay stage for edges
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scl_sync <= 2'b11; // idle bus is high
			sda_sync <= 2'b11;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
		end else begin
			scl_sync <= {scl_sync[0], scl_i};
			sda_sync <= {sda_sync[0], sda_i};
			scl_q    <= scl_sync[1];
			sda_q    <= sda_sync[1];
		end
	end

	assign scl_rise  = scl_sync[1] & ~scl_q;
	assign scl_fall  = ~scl_sync[1] & scl_q;
	assign bus_start = scl_sync[1] & scl_q & sda_q & ~sda_sync[1]; // sda falls, scl high
	assign bus_stop  = scl_sync[1] & scl_q & ~sda_q & sda_sync[1]; // sda rises, scl high

	// bit counter and bus events
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			ev_q    <= '0;
			bit_cnt <= 4'd0;
		end else begin
			ev_q       <= '0;
			ev_q.start <= bus_start;
			ev_q.stop  <= bus_stop;
			if (bus_start || bus_stop) begin
				bit_cnt <= 4'd0;
			end else if (scl_rise) begin
				if (bit_cnt == 4'd8) begin
					bit_cnt <= 4'd0;
					if (tx_busy) begin // master ack after a sent byte
						ev_q.byte_vld   <= 1'b1;
						ev_q.master_ack <= ~sda_sync[1];
					end
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'd7 && !ctl_i.tx_mode) begin
						ev_q.byte_vld <= 1'b1;
						ev_q.rx_byte  <= {rx_sh[6:0], sda_sync[1]};
					end
				end
			end
		end
	end

	// receive shift, msb first
	always_ff @(posedge sys_clk) begin
		if (scl_rise && bit_cnt < 4'd8 && !ctl_i.tx_mode) begin
			rx_sh <= {rx_sh[6:0], sda_sync[1]};
		end
	end

	// transmit shift register
	always_ff @(posedge sys_clk) begin
		if (ctl_i.tx_load) begin
			tx_sh <= ctl_i.tx_byte;
		end else if (scl_fall && bit_cnt < 4'd8 && (tx_busy || (bit_cnt == 4'd0 && tx_full))) begin
			tx_sh <= {tx_sh[6:0], 1'b0};
		end
	end

	// sda drive, changes only while scl is low
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			sda_oe_q <= 1'b0;
			tx_full  <= 1'b0;
			tx_busy  <= 1'b0;
		end else if (bus_start || bus_stop) begin
			sda_oe_q <= 1'b0;
			tx_full  <= 1'b0;
			tx_busy  <= 1'b0;
		end else begin
			if (ctl_i.tx_load) begin
				tx_full <= 1'b1;
			end
			if (scl_rise && bit_cnt == 4'd8) begin
				tx_busy <= 1'b0; // byte and its ack done
			end
			if (scl_fall) begin
				if (bit_cnt == 4'd8) begin
					// our ack, or let go for the master's ack
					sda_oe_q <= ctl_i.ack_en & ~tx_busy;
				end else if (bit_cnt == 4'd0) begin
					if (ctl_i.tx_mode && tx_full) begin
						sda_oe_q <= ~tx_sh[7]; // msb of the loaded byte
						tx_full  <= 1'b0;
						tx_busy  <= 1'b1;
					end else begin
						sda_oe_q <= 1'b0; // end of ack bit
					end
				end else if (tx_busy) begin
					sda_oe_q <= ~tx_sh[7];
				end
			end
		end
	end

	assign ev_o     = ev_q;
	assign sda_oe_o = sda_oe_q;

endmodule

`default_nettype wire

// ==== rtl/i2c_xfer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_xfer_ctrl import i2c_sensor_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  bus_ev_t    ev_i,
	input  logic [6:0] dev_addr_i,
	input  logic [7:0] rdata_i,
	output bit_ctl_t   ctl_o,
	output reg_req_t   req_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DEV,   // device address byte
		ST_RA_HI, // register address high byte
		ST_RA_LO, // register address low byte
		ST_WR,
		ST_RD
	} state_t;

	state_t      state;
	logic [15:0] reg_addr;
	logic [7:0]  wdata;
	logic        ack_en;
	logic        tx_mode;
	logic        wr_stb;
	logic        rd_stb;
	logic        load_d1;
	logic        tx_load;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			reg_addr <= 16'h0000;
			ack_en   <= 1'b0;
			tx_mode  <= 1'b0;
			wr_stb   <= 1'b0;
			rd_stb   <= 1'b0;
		end else begin
			wr_stb <= 1'b0;
			rd_stb <= 1'b0;
			if (wr_stb) begin
				reg_addr <= reg_addr + 16'd1; // step after the write lands
			end
			if (ev_i.stop) begin
				state   <= ST_IDLE;
				ack_en  <= 1'b0;
				tx_mode <= 1'b0;
			end else if (ev_i.start) begin
				state   <= ST_DEV; // reg_addr kept for repeated start
				ack_en  <= 1'b0;
				tx_mode <= 1'b0;
			end else if (ev_i.byte_vld) begin
				case (state)
					ST_DEV: begin
						if (ev_i.rx_byte[7:1] == dev_addr_i) begin
							ack_en <= 1'b1;
							if (ev_i.rx_byte[0]) begin
								state   <= ST_RD;
								tx_mode <= 1'b1;
								rd_stb  <= 1'b1; // fetch first byte at current address
							end else begin
								state <= ST_RA_HI;
							end
						end else begin
							state  <= ST_IDLE; // not us, stay off the bus
							ack_en <= 1'b0;
						end
					end
					ST_RA_HI: begin
						reg_addr[15:8] <= ev_i.rx_byte;
						ack_en         <= 1'b1;
						state          <= ST_RA_LO;
					end
					ST_RA_LO: begin
						reg_addr[7:0] <= ev_i.rx_byte;
						ack_en        <= 1'b1;
						state         <= ST_WR;
					end
					ST_WR: begin
						wr_stb <= 1'b1;
						ack_en <= 1'b1;
					end
					ST_RD: begin
						ack_en <= 1'b0;
						if (ev_i.master_ack) begin
							reg_addr <= reg_addr + 16'd1;
							rd_stb   <= 1'b1;
						end else begin
							state   <= ST_IDLE; // nack ends the read
							tx_mode <= 1'b0;
						end
					end
					default: begin
						ack_en <= 1'b0;
					end
				endcase
			end
		end
	end

	// write data capture
	always_ff @(posedge sys_clk) begin
		if (ev_i.byte_vld) begin
			wdata <= ev_i.rx_byte;
		end
	end

	// tx_load two cycles behind rd_stb, rdata valid by then
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			load_d1 <= 1'b0;
			tx_load <= 1'b0;
		end else begin
			load_d1 <= rd_stb;
			tx_load <= load_d1;
		end
	end

	assign ctl_o.ack_en  = ack_en;
	assign ctl_o.tx_mode = tx_mode;
	assign ctl_o.tx_load = tx_load;
	assign ctl_o.tx_byte = rdata_i; // held by the register file

	assign req_o.wr_stb = wr_stb;
	assign req_o.rd_stb = rd_stb;
	assign req_o.addr   = reg_addr;
	assign req_o.wdata  = wdata;

endmodule

`default_nettype wire

// ==== rtl/sensor_reg_file.sv ====
`timescale 1ns/1ps
`include "i2c_sensor_consts.svh"
`default_nettype none

module sensor_reg_file import i2c_sensor_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  reg_req_t   req_i,
	output logic [7:0] rdata_o,
	output logic [6:0] dev_addr_o
);

	localparam int RW_NUM = `REG_RW_LAST - `REG_RW_FIRST + 1;
	localparam int RW_IW  = $clog2(RW_NUM);

	logic [6:0]       dev_addr;
	logic [7:0]       rw_mem [RW_NUM];
	logic [7:0]       id_off;
	logic [RW_IW-1:0] rw_off;
	logic             in_id;
	logic             in_rw;
	logic [7:0]       rd_val;

	assign in_id  = (req_i.addr >= `REG_ID_FIRST) && (req_i.addr <= `REG_ID_LAST);
	assign in_rw  = (req_i.addr >= `REG_RW_FIRST) && (req_i.addr <= `REG_RW_LAST);
	assign id_off = req_i.addr[7:0] - 8'(`REG_ID_FIRST);
	assign rw_off = req_i.addr[RW_IW-1:0] - RW_IW'(`REG_RW_FIRST);

	// device address and read/write bytes
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dev_addr <= `I2C_RESET_ADDR;
			for (int k = 0; k < RW_NUM; k++) begin
				rw_mem[k] <= `RW_RESET_BASE + 8'(k); // B0 upwards
			end
		end else if (req_i.wr_stb) begin
			if (req_i.addr == `REG_DEVICE_ADDR) begin
				dev_addr <= req_i.wdata[6:0];
			end
			if (in_rw) begin
				rw_mem[rw_off] <= req_i.wdata;
			end
			// identity range is read only
		end
	end

	// read mux
	always_comb begin
		rd_val = `RD_FILL_VAL;
		if (req_i.addr == `REG_DEVICE_ADDR) begin
			rd_val = {1'b0, dev_addr};
		end else if (in_id) begin
			rd_val = `ID_BASE_VAL + id_off;
		end else if (in_rw) begin
			rd_val = rw_mem[rw_off];
		end
	end

	// held until the next read strobe
	always_ff @(posedge sys_clk) begin
		if (req_i.rd_stb) begin
			rdata_o <= rd_val;
		end
	end

	assign dev_addr_o = dev_addr;

endmodule

`default_nettype wire

// ==== rtl/i2c_sensor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_sensor_top import i2c_sensor_pkg::*; (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_oe_o // high pulls sda low
);

	bus_ev_t    bus_ev;
	bit_ctl_t   bit_ctl;
	reg_req_t   reg_req;
	logic [7:0] reg_rdata;
	logic [6:0] dev_addr;

	i2c_bit_engine i_bit_engine (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.scl_i    (scl_i),
		.sda_i    (sda_i),
		.ctl_i    (bit_ctl),
		.ev_o     (bus_ev),
		.sda_oe_o (sda_oe_o)
	);

	i2c_xfer_ctrl i_xfer_ctrl (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.ev_i       (bus_ev),
		.dev_addr_i (dev_addr),
		.rdata_i    (reg_rdata),
		.ctl_o      (bit_ctl),
		.req_o      (reg_req)
	);

	sensor_reg_file i_reg_file (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.req_i      (reg_req),
		.rdata_o    (reg_rdata),
		.dev_addr_o (dev_addr)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic sys_clk_o,
	output logic rst_n_o
);

	localparam int HALF_NS = 2; // 4 ns period

	initial begin
		sys_clk_o = 1'b0;
		forever #(HALF_NS) sys_clk_o = ~sys_clk_o;
	end

	// active low, held for 4 cycles
	initial begin
		rst_n_o = 1'b0;
		repeat (4) @(posedge sys_clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/i2c_sensor_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_sensor_asserts import i2c_sensor_pkg::*; (
	input logic       sys_clk,
	input logic       rst_n,
	input logic [3:0] bit_cnt_i,
	input bit_ctl_t   ctl_i,
	input bus_ev_t    ev_i,
	input logic       sda_oe_i
);

	// in receive mode the target only pulls sda for the ack bit
	sda_oe_rx_ack: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(sda_oe_i && !ctl_i.tx_mode) |-> (bit_cnt_i == 4'd8 || bit_cnt_i == 4'd0))
		else $error("sda pulled low in receive mode outside the ack bit");

	// sda has to settle between a start and a stop
	start_stop_excl: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(ev_i.start || ev_i.stop) |=> !(ev_i.start || ev_i.stop))
		else $error("start and stop in back-to-back cycles");

	// ack decision settles within 2 cycles of byte_vld
	ack_en_timely: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(ctl_i.ack_en != $past(ctl_i.ack_en)) |->
		($past(ev_i.byte_vld) || $past(ev_i.byte_vld, 2) || $past(ev_i.start) || $past(ev_i.stop)))
		else $error("ack_en changed away from a byte, start or stop event");

endmodule

bind i2c_bit_engine i2c_sensor_asserts i_asserts (
	.sys_clk   (sys_clk),
	.rst_n     (rst_n),
	.bit_cnt_i (bit_cnt),
	.ctl_i     (ctl_i),
	.ev_i      (ev_o),
	.sda_oe_i  (sda_oe_o)
);

`default_nettype wire

// ==== verif/i2c_sensor_tb.sv ====
`timescale 1ns/1ps
`include "i2c_sensor_consts.svh"
`default_nettype none

module i2c_sensor_tb;

	localparam int HALF    = 20; // sys_clk cycles per scl half period
	localparam int WDOG_NS = 6 * 40 * 18 * 80 * 2;

	logic       sys_clk;
	logic       rst_n;
	logic       scl;
	logic       sda_drv; // master side of the open-drain line
	logic       sda_oe;
	logic       sda_line;
	logic [7:0] rw_model [8];
	logic [6:0] dev_model;
	integer     seed;
	int         tests;
	int         checks;
	int         errors;
	int         err_start;

	assign sda_line = sda_drv & ~sda_oe; // pull-up

	tb_clk_gen i_clk_gen (
		.sys_clk_o (sys_clk),
		.rst_n_o   (rst_n)
	);

	i2c_sensor_top i_i2c_sensor_top (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.scl_i    (scl),
		.sda_i    (sda_line),
		.sda_oe_o (sda_oe)
	);

	function automatic logic [7:0] model_read(input logic [15:0] a);
		logic [7:0] v;
		v = `RD_FILL_VAL;
		if (a == `REG_DEVICE_ADDR)
			v = {1'b0, dev_model};
		else if (a >= `REG_ID_FIRST && a <= `REG_ID_LAST)
			v = `ID_BASE_VAL + 8'(a - `REG_ID_FIRST);
		else if (a >= `REG_RW_FIRST && a <= `REG_RW_LAST)
			v = rw_model[3'(a - `REG_RW_FIRST)];
		return v;
	endfunction

	function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
		if (a == `REG_DEVICE_ADDR)
			dev_model = d[6:0];
		else if (a >= `REG_RW_FIRST && a <= `REG_RW_LAST)
			rw_model[3'(a - `REG_RW_FIRST)] = d; // identity and unmapped writes dropped
	endfunction

	task automatic wait_clks(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("** Error at %0t: %s read %02h, expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_ack(input string what, input logic got, input logic exp);
		checks++;
		assert (got == exp) else begin
			$display("** Error at %0t: %s ack %0b, expected %0b", $time, what, got, exp);
			errors++;
		end
	endtask

	// one scl period, data set early in the low phase, sampled mid high
	task automatic clock_bit(input logic b, output logic s);
		wait_clks(4);
		sda_drv <= b;
		wait_clks(HALF - 4);
		scl <= 1'b1;
		wait_clks(HALF / 2);
		s = sda_line;
		wait_clks(HALF / 2);
		scl <= 1'b0;
	endtask

	task automatic i2c_start();
		wait_clks(4);
		sda_drv <= 1'b1;
		wait_clks(HALF - 4);
		scl <= 1'b1;
		wait_clks(HALF);
		sda_drv <= 1'b0; // falls while scl high
		wait_clks(HALF);
		scl <= 1'b0;
	endtask

	task automatic i2c_stop();
		wait_clks(4);
		sda_drv <= 1'b0;
		wait_clks(HALF - 4);
		scl <= 1'b1;
		wait_clks(HALF);
		sda_drv <= 1'b1;
		wait_clks(HALF);
	endtask

	task automatic send_byte(input logic [7:0] b, output logic acked);
		logic s;
		for (int i = 7; i >= 0; i--)
			clock_bit(b[i], s);
		clock_bit(1'b1, s); // release for the target ack
		acked = ~s;
	endtask

	task automatic recv_byte(input logic ack, output logic [7:0] b);
		logic s;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, s);
			b[i] = s;
		end
		clock_bit(~ack, s);
	endtask

	task automatic addr_phase(input logic [6:0] dev, input logic [15:0] addr);
		logic ack;
		i2c_start();
		send_byte({dev, 1'b0}, ack);
		check_ack("device address write", ack, 1'b1);
		send_byte(addr[15:8], ack);
		check_ack("register address high", ack, 1'b1);
		send_byte(addr[7:0], ack);
		check_ack("register address low", ack, 1'b1);
	endtask

	task automatic write_data(input logic [15:0] addr, input logic [7:0] d);
		logic ack;
		send_byte(d, ack);
		check_ack("write data", ack, 1'b1);
		model_write(addr, d);
	endtask

	// repeated start, then n bytes with the last one nacked
	task automatic read_check(input logic [6:0] dev, input logic [15:0] addr, input int n);
		logic       ack;
		logic [7:0] b;
		i2c_start();
		send_byte({dev, 1'b1}, ack);
		check_ack("device address read", ack, 1'b1);
		for (int k = 0; k < n; k++) begin
			recv_byte(k != n - 1, b);
			check_val($sformatf("register %04h", addr + 16'(k)), b, model_read(addr + 16'(k)));
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_start)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - err_start);
		err_start = errors;
	endtask

	task automatic test_reset_read();
		addr_phase(dev_model, `REG_ID_FIRST);
		read_check(dev_model, `REG_ID_FIRST, 12); // identity then read/write bytes
		i2c_stop();
		finish_test("reset values");
	endtask

	task automatic test_addr_miss();
		logic ack;
		i2c_start();
		send_byte({dev_model ^ 7'h01, 1'b0}, ack);
		check_ack("foreign device address", ack, 1'b0);
		i2c_stop();
		addr_phase(dev_model, `REG_RW_FIRST);
		read_check(dev_model, `REG_RW_FIRST, 1);
		i2c_stop();
		finish_test("address mismatch");
	endtask

	task automatic test_burst_write();
		addr_phase(dev_model, `REG_RW_FIRST);
		for (int k = 0; k < 8; k++)
			write_data(`REG_RW_FIRST + 16'(k), 8'($random(seed)));
		i2c_stop();
		addr_phase(dev_model, `REG_RW_FIRST);
		read_check(dev_model, `REG_RW_FIRST, 8);
		i2c_stop();
		finish_test("burst write and read back");
	endtask

	task automatic test_id_unmapped();
		addr_phase(dev_model, 16'h0002);
		write_data(16'h0002, 8'h55); // identity byte stays
		i2c_stop();
		addr_phase(dev_model, 16'h0002);
		read_check(dev_model, 16'h0002, 1);
		i2c_stop();
		addr_phase(dev_model, 16'h2000);
		read_check(dev_model, 16'h2000, 1);
		i2c_stop();
		finish_test("identity write and unmapped read");
	endtask

	task automatic test_dev_addr_change();
		logic       ack;
		logic [6:0] old_dev;
		old_dev = dev_model;
		addr_phase(dev_model, `REG_DEVICE_ADDR);
		write_data(`REG_DEVICE_ADDR, 8'h33);
		i2c_stop();
		i2c_start();
		send_byte({old_dev, 1'b1}, ack);
		check_ack("old device address", ack, 1'b0);
		i2c_stop();
		addr_phase(dev_model, `REG_DEVICE_ADDR);
		read_check(dev_model, `REG_DEVICE_ADDR, 1);
		i2c_stop();
		finish_test("device address change");
	endtask

	initial begin
		#(WDOG_NS);
		$display("timeout: the I2C transfers did not finish within %0d ns", WDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		scl       = 1'b1; // idle bus
		sda_drv   = 1'b1;
		seed      = 32'h756f_044c;
		tests     = 0;
		checks    = 0;
		errors    = 0;
		err_start = 0;
		dev_model = `I2C_RESET_ADDR;
		for (int k = 0; k < 8; k++)
			rw_model[k] = `RW_RESET_BASE + 8'(k);
		wait (rst_n === 1'b1);
		wait_clks(10);
		test_reset_read();
		test_addr_miss();
		test_burst_write();
		test_id_unmapped();
		test_dev_addr_change();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== i2c_sensor_top.f ====
+incdir+rtl
rtl/i2c_sensor_pkg.sv
rtl/i2c_bit_engine.sv
rtl/i2c_xfer_ctrl.sv
rtl/sensor_reg_file.sv
rtl/i2c_sensor_top.sv
verif/tb_clk_gen.sv
verif/i2c_sensor_asserts.sv
verif/i2c_sensor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the I2C sensor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module i2c_sensor_tb -f i2c_sensor_top.f \
	--Mdir obj_dir -o i2c_sensor_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/i2c_sensor_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
